/* filelist.f */
+incdir+tb
verilog/isa_pkg.sv
verilog/exec_pkg.sv
verilog/uop_issue.sv
verilog/uop_queue.sv
verilog/cond_eval.sv
verilog/bitfield_move.sv
verilog/alu_execute.sv
verilog/exec_top.sv
tb/exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ns

SRCS := $(wildcard verilog/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// arm condition table
function automatic logic eval_condition(input cond_t cond, input nzcv_t f);
  logic ge;
  ge = (f.n == f.v);
  case (cond)
    C_EQ: return f.z;
    C_NE: return !f.z;
    C_CS: return f.c;
    C_CC: return !f.c;
    C_MI: return f.n;
    C_PL: return !f.n;
    C_VS: return f.v;
    C_VC: return !f.v;
    C_HI: return f.c && !f.z;
    C_LS: return !f.c || f.z;
    C_GE: return ge;
    C_LT: return !ge;
    C_GT: return ge && !f.z;
    C_LE: return !ge || f.z;
    default: return 1'b1;
  endcase
endfunction

// bit by bit copy of the field and sign fill above its top bit
function automatic logic [GPR_SIZE-1:0] bitfield_result(input logic [GPR_SIZE-1:0] src,
    input logic [5:0] immr, input logic [5:0] imms, input logic sign);
  logic [GPR_SIZE-1:0] res;
  int r;
  int s;
  int top;
  res = '0;
  r = int'(immr);
  s = int'(imms);
  if (s >= r) begin
    for (int i = 0; i <= s - r; i++) res[6'(i)] = src[6'(r + i)];
    top = s - r;
  end else begin
    // low bits of the source land at 64-immr
    for (int i = 0; i <= s; i++) res[6'(GPR_SIZE - r + i)] = src[6'(i)];
    top = GPR_SIZE - r + s;
  end
  if (sign && src[imms]) begin
    for (int i = top + 1; i < GPR_SIZE; i++) res[6'(i)] = 1'b1;
  end
  return res;
endfunction

function automatic logic [GPR_SIZE-1:0] op_result(input alu_op_t op,
    input logic [GPR_SIZE-1:0] a, input logic [GPR_SIZE-1:0] b, input imm_ctl_u ctl,
    input logic passed);
  case (op)
    ALU_OP_PLUS:   return a + b;
    ALU_OP_MINUS:  return a - b;
    ALU_OP_ORN:    return a | ~b;
    ALU_OP_OR:     return a | b;
    ALU_OP_EOR:    return a ^ b;
    ALU_OP_AND:    return a & b;
    ALU_OP_MOV:    return a | (b << ctl.mv.shift);
    ALU_OP_PASS_A: return a;
    ALU_OP_UBFM:   return bitfield_result(a, ctl.bf.immr, ctl.bf.imms, 1'b0);
    ALU_OP_SBFM:   return bitfield_result(a, ctl.bf.immr, ctl.bf.imms, 1'b1);
    ALU_OP_CSEL:   return passed ? a : b;
    ALU_OP_CSINC:  return passed ? a : b + GPR_SIZE'(1);
    ALU_OP_CSINV:  return passed ? a : ~b;
    ALU_OP_CSNEG:  return passed ? a : ~b + GPR_SIZE'(1);
    default:       return '0;
  endcase
endfunction

// expected result for one issue from the flags left by the previous one
function automatic result_t expected_result(input issue_word_t w,
    input logic [GPR_SIZE-1:0] a, input logic [GPR_SIZE-1:0] b, input nzcv_t cur,
    input logic [TAG_W-1:0] tag);
  result_t r;
  logic [GPR_SIZE-1:0] opb;
  logic [GPR_SIZE:0] u;
  logic signed [GPR_SIZE:0] s;
  opb = w.use_imm ? GPR_SIZE'(w.imm10) : b;
  r.tag = tag;
  r.cond_passed = eval_condition(w.cond, cur);
  r.value = op_result(w.op, a, opb, w.ctl, r.cond_passed);
  r.flags = cur;
  if (w.set_flags) begin
    r.flags = '0;
    r.flags.n = r.value[GPR_SIZE-1];
    r.flags.z = (r.value == '0);
    if (w.op == ALU_OP_PLUS) begin
      u = {1'b0, a} + {1'b0, opb};
      s = $signed({a[GPR_SIZE-1], a}) + $signed({opb[GPR_SIZE-1], opb});
      r.flags.c = u[GPR_SIZE];
      r.flags.v = s[GPR_SIZE] ^ s[GPR_SIZE-1];
    end else if (w.op == ALU_OP_MINUS) begin
      // carry is the inverse of the borrow out of bit 63
      u = {1'b0, a} - {1'b0, opb};
      s = $signed({a[GPR_SIZE-1], a}) - $signed({opb[GPR_SIZE-1], opb});
      r.flags.c = !u[GPR_SIZE];
      r.flags.v = s[GPR_SIZE] ^ s[GPR_SIZE-1];
    end
  end
  return r;
endfunction

`endif

/* tb/exec_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_tb;
  import isa_pkg::*;
  import exec_pkg::*;

  `include "exec_model.svh"

  localparam int DEPTH = 4;
  localparam int TIMEOUT = 200;
  localparam int RANDOM_ISSUES = 3000;
  // setups leaving zero, negative, overflow and all clear flags
  localparam alu_op_t SETUP_OP [4] = '{ALU_OP_MINUS, ALU_OP_MINUS, ALU_OP_MINUS, ALU_OP_PLUS};
  localparam logic [63:0] SETUP_A [4] = '{64'd5, 64'd3, 64'h8000_0000_0000_0000, 64'd1};
  localparam logic [63:0] SETUP_B [4] = '{64'd5, 64'd5, 64'd1, 64'd1};
  localparam alu_op_t LOGIC_OP [6] = '{ALU_OP_ORN, ALU_OP_OR, ALU_OP_EOR, ALU_OP_AND,
                                       ALU_OP_MOV, ALU_OP_PASS_A};
  localparam logic [5:0] BF_IMMR [6] = '{6'd4, 6'd8, 6'd20, 6'd0, 6'd63, 6'd1};
  localparam logic [5:0] BF_IMMS [6] = '{6'd11, 6'd8, 6'd7, 6'd63, 6'd0, 6'd62};
  localparam logic [63:0] BF_SRC [3] = '{64'h8000_0000_0000_0980, 64'hfedc_ba98_7654_3210,
                                         64'h0000_0000_0000_0001};

  logic                clk;
  logic                reset;
  logic                issue;
  issue_word_t         issue_word;
  logic [GPR_SIZE-1:0] reg_a;
  logic [GPR_SIZE-1:0] reg_b;
  logic                hold;
  logic                full;
  logic                result_valid;
  result_t             result;

  int               seed = 32'h08e1223d;
  nzcv_t            ref_flags;
  logic [TAG_W-1:0] next_tag;
  result_t          expected_q[$];

  exec_top #(
    .DEPTH (DEPTH)
  ) DUT (
    .clk          (clk),
    .reset        (reset),
    .issue        (issue),
    .issue_word   (issue_word),
    .reg_a        (reg_a),
    .reg_b        (reg_b),
    .hold         (hold),
    .full         (full),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_field(input string name, input logic [63:0] want, input logic [63:0] got);
    assert (want === got) else begin
      fail_run($sformatf("[ERROR] %s expected %0h actual %0h", name, want, got));
    end
  endtask

  // starts on a falling edge and returns on the next one
  task automatic issue_uop(input alu_op_t op, input cond_t cond, input logic sf,
      input logic use_imm, input logic [11:0] ctl, input logic [9:0] imm10,
      input logic [GPR_SIZE-1:0] a, input logic [GPR_SIZE-1:0] b);
    issue_word_t w;
    result_t     want;
    int          waited;
    waited = 0;
    while (full) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) fail_run("timeout: full stayed high while waiting to issue");
    end
    w.op = op;
    w.cond = cond;
    w.set_flags = sf;
    w.use_imm = use_imm;
    w.ctl = imm_ctl_u'(ctl);
    w.imm10 = imm10;
    want = expected_result(w, a, b, ref_flags, next_tag);
    ref_flags = want.flags;
    next_tag = next_tag + TAG_W'(1);
    expected_q.push_back(want);
    issue = 1'b1;
    issue_word = w;
    reg_a = a;
    reg_b = b;
    @(negedge clk);
    issue = 1'b0;
  endtask

  task automatic random_uop();
    logic [GPR_SIZE-1:0] a;
    logic [GPR_SIZE-1:0] b;
    alu_op_t             op;
    op = alu_op_t'(4'($unsigned($random(seed)) % 14));
    a = {$random(seed), $random(seed)};
    b = {$random(seed), $random(seed)};
    if (($random(seed) & 7) == 0) b = a;
    issue_uop(op, cond_t'(4'($random(seed))), 1'($random(seed)), 1'($random(seed)),
              12'($random(seed)), 10'($random(seed)), a, b);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) fail_run("timeout: results stopped arriving");
    end
  endtask

  task automatic measure_latency();
    int cycles;
    wait_drained();
    hold = 1'b0;
    issue_uop(ALU_OP_PLUS, C_AL, 1'b1, 1'b0, '0, '0, 64'd40, 64'd2);
    cycles = 1;
    while (!result_valid) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) fail_run("timeout: no result after a single issue");
    end
    check_field("latency", 64'(3), 64'(cycles));
  endtask

  // scoreboard compare on the falling edge
  always @(negedge clk) begin
    result_t want;
    if (!reset && result_valid) begin
      assert (expected_q.size() > 0) else begin
        fail_run("result strobe arrived with no micro-op outstanding");
      end
      want = expected_q.pop_front();
      check_field("result.tag", 64'(want.tag), 64'(result.tag));
      check_field("result.value", want.value, result.value);
      check_field("result.flags", 64'(want.flags), 64'(result.flags));
      check_field("result.cond_passed", 64'(want.cond_passed), 64'(result.cond_passed));
    end
  end

  initial begin
    int count;
    reset = 1'b1;
    issue = 1'b0;
    issue_word = '0;
    reg_a = '0;
    reg_b = '0;
    hold = 1'b0;
    ref_flags = '0;
    next_tag = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    measure_latency();
    issue_uop(ALU_OP_PLUS, C_AL, 1'b1, 1'b0, '0, '0, '1, 64'd1);
    issue_uop(ALU_OP_PLUS, C_AL, 1'b1, 1'b0, '0, '0, 64'h7fff_ffff_ffff_ffff, 64'd1);
    issue_uop(ALU_OP_PLUS, C_AL, 1'b1, 1'b0, '0, '0, 64'h8000_0000_0000_0000,
              64'h8000_0000_0000_0000);
    issue_uop(ALU_OP_MINUS, C_AL, 1'b1, 1'b0, '0, '0, 64'd5, 64'd5);
    issue_uop(ALU_OP_PLUS, C_AL, 1'b0, 1'b0, '0, '0, 64'd2, 64'd3);
    issue_uop(ALU_OP_MINUS, C_AL, 1'b1, 1'b0, '0, '0, 64'd3, 64'd5);
    issue_uop(ALU_OP_MINUS, C_AL, 1'b0, 1'b0, '0, '0, 64'd1, 64'd2);
    issue_uop(ALU_OP_MINUS, C_AL, 1'b1, 1'b1, '0, 10'd1, 64'h8000_0000_0000_0000, '0);

    foreach (LOGIC_OP[i]) begin
      for (int u = 0; u < 2; u++) begin
        issue_uop(LOGIC_OP[i], C_AL, 1'b1, 1'(u), {6'h15, 6'(i * 11)}, 10'h2b7,
                  64'h0123_4567_89ab_cdef, 64'hf0f0_0ff0_5a5a_a5a5);
      end
    end
    issue_uop(ALU_OP_MOV, C_AL, 1'b1, 1'b1, {6'h00, 6'd63}, 10'h001, 64'd0, '0);

    for (int c = 0; c < 16; c++) begin
      for (int k = 0; k < 4; k++) begin
        for (int s = 0; s < 4; s++) begin
          issue_uop(SETUP_OP[k], C_AL, 1'b1, 1'b0, '0, '0, SETUP_A[k], SETUP_B[k]);
          issue_uop(alu_op_t'(4'(7 + s)), cond_t'(4'(c)), 1'(s), 1'b0, '0, '0,
                    64'h1111_2222_3333_4444, 64'h0000_0000_0000_00ff);
        end
      end
    end

    foreach (BF_SRC[j]) begin
      foreach (BF_IMMR[i]) begin
        issue_uop(ALU_OP_UBFM, C_AL, 1'b1, 1'b0, {BF_IMMR[i], BF_IMMS[i]}, '0, BF_SRC[j], '0);
        issue_uop(ALU_OP_SBFM, C_AL, 1'b1, 1'b0, {BF_IMMR[i], BF_IMMS[i]}, '0, BF_SRC[j], '0);
      end
    end

    // fill the queue under hold and let it drain
    wait_drained();
    hold = 1'b1;
    count = 0;
    while (!full) begin
      random_uop();
      count++;
      if (count > 2 * DEPTH + 2) fail_run("timeout: full did not rise while hold was high");
    end
    // DEPTH-1 queue entries plus the one in the issue register
    check_field("issues before full", 64'(DEPTH), 64'(count));
    repeat (4) @(negedge clk);
    hold = 1'b0;
    wait_drained();

    for (int n = 0; n < RANDOM_ISSUES; n++) begin
      hold = (($random(seed) & 3) == 0);
      if (full) hold = 1'b0;
      random_uop();
    end
    hold = 1'b0;
    wait_drained();

    if (expected_q.size() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("%0d results never arrived", expected_q.size());
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/exec_top.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_top #(
  parameter int DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          issue,
  input  isa_pkg::issue_word_t          issue_word,
  input  logic [exec_pkg::GPR_SIZE-1:0] reg_a,
  input  logic [exec_pkg::GPR_SIZE-1:0] reg_b,
  input  logic                          hold,
  output logic                          full,
  output logic                          result_valid,
  output exec_pkg::result_t             result
);
  import exec_pkg::*;

  logic uop_push;
  logic empty;
  logic pop;
  uop_t uop_in;
  uop_t uop_out;

  uop_issue u_uop_issue (
    .clk        (clk),
    .reset      (reset),
    .issue      (issue),
    .issue_word (issue_word),
    .reg_a      (reg_a),
    .reg_b      (reg_b),
    .uop_push   (uop_push),
    .uop_in     (uop_in)
  );

  uop_queue #(
    .DEPTH (DEPTH)
  ) u_uop_queue (
    .clk      (clk),
    .reset    (reset),
    .uop_push (uop_push),
    .uop_in   (uop_in),
    .pop      (pop),
    .uop_out  (uop_out),
    .empty    (empty),
    .full     (full)
  );

  alu_execute u_alu_execute (
    .clk          (clk),
    .reset        (reset),
    .uop_out      (uop_out),
    .empty        (empty),
    .hold         (hold),
    .pop          (pop),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

/* verilog/alu_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_execute (
  input  logic              clk,
  input  logic              reset,
  input  exec_pkg::uop_t    uop_out,
  input  logic              empty,
  input  logic              hold,
  output logic              pop,
  output logic              result_valid,
  output exec_pkg::result_t result
);
  import isa_pkg::*;
  import exec_pkg::*;

  logic [GPR_SIZE-1:0] val_a;
  logic [GPR_SIZE-1:0] val_b;
  logic [GPR_SIZE:0]   sum_ext;
  logic [GPR_SIZE-1:0] diff;
  logic [GPR_SIZE-1:0] bf_res;
  logic [GPR_SIZE-1:0] alu_val;
  logic                holds;
  logic                is_sbfm;
  nzcv_t               flags;
  nzcv_t               next_flags;

  assign val_a   = uop_out.val_a;
  assign val_b   = uop_out.val_b;
  assign pop     = ~empty & ~hold;
  assign sum_ext = {1'b0, val_a} + {1'b0, val_b};
  assign diff    = val_a - val_b;
  assign is_sbfm = (uop_out.op == ALU_OP_SBFM);

  // condition sees the flags left by the previous micro-op
  cond_eval u_cond_eval (
    .cond  (uop_out.cond),
    .flags (flags),
    .holds (holds)
  );

  bitfield_move u_bitfield_move (
    .val  (val_a),
    .immr (uop_out.ctl.bf.immr),
    .imms (uop_out.ctl.bf.imms),
    .sign (is_sbfm),
    .res  (bf_res)
  );

  always_comb begin
    case (uop_out.op)
      ALU_OP_PLUS:   alu_val = sum_ext[GPR_SIZE-1:0];
      ALU_OP_MINUS:  alu_val = diff;
      ALU_OP_ORN:    alu_val = val_a | ~val_b;
      ALU_OP_OR:     alu_val = val_a | val_b;
      ALU_OP_EOR:    alu_val = val_a ^ val_b;
      ALU_OP_AND:    alu_val = val_a & val_b;
      ALU_OP_MOV:    alu_val = val_a | (val_b << uop_out.ctl.mv.shift);
      ALU_OP_PASS_A: alu_val = val_a;
      ALU_OP_UBFM,
      ALU_OP_SBFM:   alu_val = bf_res;
      ALU_OP_CSEL:   alu_val = holds ? val_a : val_b;
      ALU_OP_CSINC:  alu_val = holds ? val_a : val_b + GPR_SIZE'(1);
      ALU_OP_CSINV:  alu_val = holds ? val_a : ~val_b;
      ALU_OP_CSNEG:  alu_val = holds ? val_a : -val_b;
      default:       alu_val = '0;
    endcase
  end

  always_comb begin
    next_flags = flags;
    if (uop_out.set_flags) begin
      next_flags.n = alu_val[GPR_SIZE-1];
      next_flags.z = (alu_val == '0);
      next_flags.c = 1'b0;
      next_flags.v = 1'b0;
      if (uop_out.op == ALU_OP_PLUS) begin
        next_flags.c = sum_ext[GPR_SIZE];
        next_flags.v = (val_a[GPR_SIZE-1] == val_b[GPR_SIZE-1]) &&
                       (alu_val[GPR_SIZE-1] != val_a[GPR_SIZE-1]);
      end else if (uop_out.op == ALU_OP_MINUS) begin
        // no borrow
        next_flags.c = (val_a >= val_b);
        next_flags.v = (val_a[GPR_SIZE-1] != val_b[GPR_SIZE-1]) &&
                       (alu_val[GPR_SIZE-1] != val_a[GPR_SIZE-1]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      flags        <= '0;
    end else begin
      result_valid <= pop;
      if (pop) begin
        flags <= next_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      result.tag         <= uop_out.tag;
      result.value       <= alu_val;
      result.flags       <= next_flags;
      result.cond_passed <= holds;
    end
  end

endmodule

`default_nettype wire

/* verilog/bitfield_move.sv */
`timescale 1ns/1ns
`default_nettype none

module bitfield_move (
  input  logic [exec_pkg::GPR_SIZE-1:0] val,
  input  logic [5:0]                    immr,
  input  logic [5:0]                    imms,
  input  logic                          sign,
  output logic [exec_pkg::GPR_SIZE-1:0] res
);
  import exec_pkg::*;

  logic [6:0]          lshift;
  logic [5:0]          top_bit;
  logic [GPR_SIZE-1:0] rot;
  logic [GPR_SIZE-1:0] tmask;
  logic [GPR_SIZE-1:0] low_mask;
  logic [GPR_SIZE-1:0] field_mask;
  logic [GPR_SIZE-1:0] ext_bits;

  assign lshift = 7'd64 - {1'b0, immr};
  assign rot    = (val >> immr) | (val << lshift);

  // field top bit, wraps to 64-immr+imms when imms < immr
  assign top_bit = imms - immr;
  assign tmask   = (GPR_SIZE'(2) << top_bit) - GPR_SIZE'(1);

  // bits below the field placed at 64-immr
  assign low_mask   = (GPR_SIZE'(1) << lshift) - GPR_SIZE'(1);
  assign field_mask = (imms >= immr) ? tmask : (tmask & ~low_mask);

  assign ext_bits = (sign && val[imms]) ? ~tmask : '0;
  assign res      = (rot & field_mask) | ext_bits;

endmodule

`default_nettype wire

/* verilog/cond_eval.sv */
`timescale 1ns/1ns
`default_nettype none

module cond_eval (
  input  isa_pkg::cond_t cond,
  input  isa_pkg::nzcv_t flags,
  output logic           holds
);
  import isa_pkg::*;

  always_comb begin
    case (cond)
      C_EQ: holds = flags.z;
      C_NE: holds = ~flags.z;
      C_CS: holds = flags.c;
      C_CC: holds = ~flags.c;
      C_MI: holds = flags.n;
      C_PL: holds = ~flags.n;
      C_VS: holds = flags.v;
      C_VC: holds = ~flags.v;
      // unsigned higher
      C_HI: holds = flags.c & ~flags.z;
      C_LS: holds = ~(flags.c & ~flags.z);
      C_GE: holds = (flags.n == flags.v);
      C_LT: holds = (flags.n != flags.v);
      C_GT: holds = (flags.n == flags.v) & ~flags.z;
      C_LE: holds = ~((flags.n == flags.v) & ~flags.z);
      default: holds = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/uop_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module uop_queue #(
  parameter int DEPTH = 4
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           uop_push,
  input  exec_pkg::uop_t uop_in,
  input  logic           pop,
  output exec_pkg::uop_t uop_out,
  output logic           empty,
  output logic           full
);
  import exec_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  // one slot kept for the micro-op still in the issue register
  localparam logic [PTR_W:0] FULL_LEVEL = (PTR_W+1)'(DEPTH - 1);

  uop_t             mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic             do_pop;

  assign do_pop  = pop & ~empty;
  assign empty   = (count == '0);
  assign full    = (count >= FULL_LEVEL);
  assign uop_out = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (uop_push) begin
      mem[wr_ptr] <= uop_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (uop_push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({uop_push, do_pop})
        2'b10:   count <= count + (PTR_W+1)'(1);
        2'b01:   count <= count - (PTR_W+1)'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/uop_issue.sv */
`timescale 1ns/1ns
`default_nettype none

module uop_issue (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            issue,
  input  isa_pkg::issue_word_t            issue_word,
  input  logic [exec_pkg::GPR_SIZE-1:0]   reg_a,
  input  logic [exec_pkg::GPR_SIZE-1:0]   reg_b,
  output logic                            uop_push,
  output exec_pkg::uop_t                  uop_in
);
  import exec_pkg::*;

  logic [TAG_W-1:0]    tag_cnt;
  logic [GPR_SIZE-1:0] operand_b;

  // immediate is zero extended
  assign operand_b = issue_word.use_imm ?
                     {{(GPR_SIZE-10){1'b0}}, issue_word.imm10} : reg_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      uop_push <= 1'b0;
      tag_cnt  <= '0;
    end else begin
      uop_push <= issue;
      if (issue) begin
        tag_cnt <= tag_cnt + TAG_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      uop_in.tag       <= tag_cnt;
      uop_in.op        <= issue_word.op;
      uop_in.cond      <= issue_word.cond;
      uop_in.set_flags <= issue_word.set_flags;
      uop_in.ctl       <= issue_word.ctl;
      uop_in.val_a     <= reg_a;
      uop_in.val_b     <= operand_b;
    end
  end

endmodule

`default_nettype wire

/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

  // bitfield logic and 6-bit fields assume 64
  localparam int GPR_SIZE = 64;
  localparam int TAG_W = 8;

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    isa_pkg::alu_op_t    op;
    isa_pkg::cond_t      cond;
    logic                set_flags;
    isa_pkg::imm_ctl_u   ctl;
    logic [GPR_SIZE-1:0] val_a;
    logic [GPR_SIZE-1:0] val_b;
  } uop_t;

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [GPR_SIZE-1:0] value;
    isa_pkg::nzcv_t      flags;
    logic                cond_passed;
  } result_t;

endpackage

`default_nettype wire

/* verilog/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  typedef enum logic [3:0] {
    ALU_OP_PLUS   = 4'd0,
    ALU_OP_MINUS  = 4'd1,
    ALU_OP_ORN    = 4'd2,
    ALU_OP_OR     = 4'd3,
    ALU_OP_EOR    = 4'd4,
    ALU_OP_AND    = 4'd5,
    ALU_OP_MOV    = 4'd6,
    ALU_OP_CSEL   = 4'd7,
    ALU_OP_CSINC  = 4'd8,
    ALU_OP_CSINV  = 4'd9,
    ALU_OP_CSNEG  = 4'd10,
    ALU_OP_PASS_A = 4'd11,
    ALU_OP_UBFM   = 4'd12,
    ALU_OP_SBFM   = 4'd13
  } alu_op_t;

  // arm encoding order
  typedef enum logic [3:0] {
    C_EQ, C_NE, C_CS, C_CC, C_MI, C_PL, C_VS, C_VC,
    C_HI, C_LS, C_GE, C_LT, C_GT, C_LE, C_AL, C_NV
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  typedef struct packed {
    logic [5:0] immr;
    logic [5:0] imms;
  } bf_ctl_t;

  typedef struct packed {
    logic [5:0] rsvd;
    logic [5:0] shift;
  } mov_ctl_t;

  // same 12 bits, read per operation
  typedef union packed {
    bf_ctl_t  bf;
    mov_ctl_t mv;
  } imm_ctl_u;

  typedef struct packed {
    alu_op_t    op;
    cond_t      cond;
    logic       set_flags;
    logic       use_imm;
    imm_ctl_u   ctl;
    logic [9:0] imm10;
  } issue_word_t;

endpackage

`default_nettype wire
